//--- src/stackMemory_params.svh
`ifndef STACKMEMORY_PARAMS_SVH
`define STACKMEMORY_PARAMS_SVH

// Byte address width of the data memory, 1024 bytes
`define MEM_ADDR_WIDTH 10

// User stack region, grows down from the top
`define USER_STACK_LOW 32'd28
`define USER_STACK_TOP 32'd41

// Privileged stack region
`define PRIV_STACK_LOW 32'd42
`define PRIV_STACK_TOP 32'd55

`define SP_EMPTY 32'hFFFF_FFFF // Empty stack marker
`define PC_STEP  32'd2         // Instructions are two bytes

`endif

//--- src/MemoryPkg.sv
`default_nettype none

`include "stackMemory_params.svh"

package MemoryPkg;

  // Control codes from the control unit
  typedef enum logic [2:0] {
    ctrlIdle = 3'd0,
    ctrlPush = 3'd1,
    ctrlPop  = 3'd2,
    ctrlByte = 3'd3,
    ctrlHalf = 3'd4,
    ctrlWord = 3'd5,
    ctrlJump = 3'd6
  } memControl_e;

  // Data word, whole or split into byte lanes (lane 0 is the LSB)
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lanes;
  } dataWord_u;

  typedef logic [3:0][`MEM_ADDR_WIDTH-1:0] byteAddrs_t; // One address per lane

endpackage

`default_nettype wire

//--- src/MemBusIf.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

// APB link between the byte sequencer and the data memory
interface MemBusIf;

  logic [`MEM_ADDR_WIDTH-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [7:0]                 pwdata;
  logic [7:0]                 prdata;
  logic                       pready;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready
  );

endinterface

`default_nettype wire

//--- src/MemoryAddressHandler.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

module MemoryAddressHandler import MemoryPkg::*; (
  input  memControl_e                control,
  input  logic                       mode,          // 0 user, 1 privileged
  input  logic [31:0]                resultAddress, // From the ALU
  input  logic [31:0]                pc,
  input  logic [31:0]                sp,
  output logic [31:0]                nextPc,
  output logic [31:0]                nextSp,
  output byteAddrs_t                 byteAddrs,
  output logic [2:0]                 byteCount,
  output logic                       writeAccess,
  output logic [`MEM_ADDR_WIDTH-1:0] instAddr0,
  output logic [`MEM_ADDR_WIDTH-1:0] instAddr1
);

  logic [31:0]                effPc;
  logic [31:0]                stackLow;
  logic [31:0]                stackTop;
  logic [31:0]                spDown;
  logic [31:0]                spUp;
  logic [`MEM_ADDR_WIDTH-1:0] baseAddr;

  // Jump takes the ALU result as the new PC
  assign effPc     = (control == ctrlJump) ? resultAddress : pc;
  assign nextPc    = effPc + `PC_STEP;
  assign instAddr0 = effPc[`MEM_ADDR_WIDTH-1:0];
  assign instAddr1 = instAddr0 - 1'b1;

  assign stackLow = mode ? `PRIV_STACK_LOW : `USER_STACK_LOW;
  assign stackTop = mode ? `PRIV_STACK_TOP : `USER_STACK_TOP;
  assign spDown   = sp - 32'd1;
  assign spUp     = sp + 32'd1;
  assign baseAddr = resultAddress[`MEM_ADDR_WIDTH-1:0];

  always_comb begin
    nextSp      = sp;
    byteAddrs   = '0;
    byteCount   = 3'd0;
    writeAccess = 1'b0;

    case (control)
      ctrlPush: begin
        writeAccess = 1'b1;
        if (sp == `SP_EMPTY) begin
          byteAddrs[0] = stackTop[`MEM_ADDR_WIDTH-1:0]; // First item at the top
          nextSp       = stackTop;
          byteCount    = 3'd1;
        end else if (sp > stackLow && sp <= stackTop) begin
          byteAddrs[0] = spDown[`MEM_ADDR_WIDTH-1:0];
          nextSp       = spDown;
          byteCount    = 3'd1;
        end
        // Full stack drops the push
      end

      ctrlPop: begin
        if (sp >= stackLow && sp < stackTop) begin
          byteAddrs[0] = sp[`MEM_ADDR_WIDTH-1:0];
          nextSp       = spUp;
          byteCount    = 3'd1;
        end else if (sp == stackTop) begin
          byteAddrs[0] = sp[`MEM_ADDR_WIDTH-1:0]; // Last item
          nextSp       = `SP_EMPTY;
          byteCount    = 3'd1;
        end else begin
          nextSp = `SP_EMPTY; // Nothing to read
        end
      end

      ctrlByte, ctrlHalf, ctrlWord: begin
        writeAccess = resultAddress[31]; // Top bit marks a store
        for (int k = 0; k < 4; k++) begin
          byteAddrs[k] = baseAddr - k[`MEM_ADDR_WIDTH-1:0];
        end
        case (control)
          ctrlByte: byteCount = 3'd1;
          ctrlHalf: byteCount = 3'd2;
          default:  byteCount = 3'd4;
        endcase
      end

      default: begin
        byteCount = 3'd0; // Idle and jump touch no data
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/StackPointerBank.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

module StackPointerBank (
  input  logic        clock,
  input  logic        reset,
  input  logic        commit,
  input  logic        mode,
  input  logic [31:0] nextPc,
  input  logic [31:0] nextSp,
  output logic [31:0] pc,
  output logic [31:0] sp
);

  logic [31:0] userSp;
  logic [31:0] privSp;

  assign sp = mode ? privSp : userSp; // Mode bit picks the active stack

  always_ff @(posedge clock) begin
    if (reset) begin
      pc     <= 32'd0;
      userSp <= `SP_EMPTY;
      privSp <= `SP_EMPTY;
    end else if (commit) begin
      pc <= nextPc;
      // Only the active pointer moves
      if (mode) privSp <= nextSp;
      else      userSp <= nextSp;
    end
  end

endmodule

`default_nettype wire

//--- src/ByteTransferSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module ByteTransferSequencer import MemoryPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  byteAddrs_t byteAddrs,
  input  logic [2:0] byteCount,
  input  logic       writeAccess,
  input  dataWord_u  writeData,
  output dataWord_u  readData,
  output logic       busy,
  output logic       done,
  output logic       commit,
  MemBusIf.master    bus
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    FINISH
  } seqState_e;

  seqState_e  state;
  logic [1:0] lane;     // Current byte lane
  logic       lastLane;

  assign lastLane = ({1'b0, lane} == byteCount - 3'd1);

  assign busy   = (state != IDLE);
  assign done   = (state == FINISH);
  assign commit = (state == FINISH); // Register bank loads on this

  // APB master outputs
  assign bus.psel    = (state == SETUP) || (state == ACCESS);
  assign bus.penable = (state == ACCESS);
  assign bus.pwrite  = writeAccess & bus.psel;
  assign bus.paddr   = byteAddrs[lane];
  assign bus.pwdata  = writeData.lanes[lane];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
      lane  <= 2'd0;
    end else begin
      case (state)
        IDLE: begin
          lane <= 2'd0;
          if (start) begin
            state <= (byteCount == 3'd0) ? FINISH : SETUP;
          end
        end
        SETUP: state <= ACCESS;
        ACCESS: begin
          if (bus.pready) begin
            if (lastLane) begin
              state <= FINISH;
            end else begin
              lane  <= lane + 2'd1;
              state <= SETUP;
            end
          end
        end
        default: state <= IDLE; // FINISH lasts one cycle
      endcase
    end
  end

  // Read data assembly, unused lanes stay zero
  always_ff @(posedge clock) begin
    if (state == IDLE && start) begin
      readData.word <= 32'd0;
    end else if (state == ACCESS && bus.pready && !writeAccess) begin
      readData.lanes[lane] <= bus.prdata;
    end
  end

endmodule

`default_nettype wire

//--- src/ByteMemory.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

module ByteMemory (
  input  logic    clock,
  input  logic    reset,
  MemBusIf.slave  bus
);

  localparam int Depth = 1 << `MEM_ADDR_WIDTH;

  logic [7:0] mem [Depth];

  assign bus.pready = 1'b1;             // No wait states
  assign bus.prdata = mem[bus.paddr];   // Read in the same cycle

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= 8'd0;
      end
    end else if (bus.psel && bus.penable && bus.pwrite) begin
      // Store on the access phase
      mem[bus.paddr] <= bus.pwdata;
    end
  end

endmodule

`default_nettype wire

//--- src/MemoryAccessUnit.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

module MemoryAccessUnit import MemoryPkg::*; (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       start,
  input  logic [2:0]                 control,
  input  logic                       mode,
  input  logic [31:0]                resultAddress,
  input  logic [31:0]                writeData,
  output logic                       busy,
  output logic                       done,
  output logic [31:0]                readData,
  output logic [31:0]                pc,
  output logic [`MEM_ADDR_WIDTH-1:0] instAddr0,
  output logic [`MEM_ADDR_WIDTH-1:0] instAddr1
);

  logic [31:0] sp;
  logic [31:0] nextPc;
  logic [31:0] nextSp;
  byteAddrs_t  byteAddrs;
  logic [2:0]  byteCount;
  logic        writeAccess;
  logic        commit;

  MemBusIf memBus ();

  MemoryAddressHandler addrHandler (
    .control       (memControl_e'(control)),
    .mode          (mode),
    .resultAddress (resultAddress),
    .pc            (pc),
    .sp            (sp),
    .nextPc        (nextPc),
    .nextSp        (nextSp),
    .byteAddrs     (byteAddrs),
    .byteCount     (byteCount),
    .writeAccess   (writeAccess),
    .instAddr0     (instAddr0),
    .instAddr1     (instAddr1)
  );

  StackPointerBank spBank (
    .clock  (clock),
    .reset  (reset),
    .commit (commit),
    .mode   (mode),
    .nextPc (nextPc),
    .nextSp (nextSp),
    .pc     (pc),
    .sp     (sp)
  );

  ByteTransferSequencer sequencer (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .byteAddrs   (byteAddrs),
    .byteCount   (byteCount),
    .writeAccess (writeAccess),
    .writeData   (writeData),
    .readData    (readData),
    .busy        (busy),
    .done        (done),
    .commit      (commit),
    .bus         (memBus.master)
  );

  ByteMemory dataMem (
    .clock (clock),
    .reset (reset),
    .bus   (memBus.slave)
  );

endmodule

`default_nettype wire

//--- dv/MemoryAccessUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "stackMemory_params.svh"

module MemoryAccessUnitTb import MemoryPkg::*; ;

  localparam int ClockPeriod = 40;
  localparam int MaxLines    = 64;
  localparam int Columns     = 7; // Words per golden line
  localparam int MaxWords    = MaxLines * Columns;

  logic                       clock;
  logic                       reset;
  logic                       start;
  logic [2:0]                 control;
  logic                       mode;
  logic [31:0]                resultAddress;
  logic [31:0]                writeData;
  logic                       busy;
  logic                       done;
  logic [31:0]                readData;
  logic [31:0]                pc;
  logic [`MEM_ADDR_WIDTH-1:0] instAddr0;
  logic [`MEM_ADDR_WIDTH-1:0] instAddr1;

  logic [31:0] goldenMem [MaxWords];
  int          lineCount;
  int          currentLine;
  logic        goldenLoaded;

  MemoryAccessUnit uut (
    .clock         (clock),
    .reset         (reset),
    .start         (start),
    .control       (control),
    .mode          (mode),
    .resultAddress (resultAddress),
    .writeData     (writeData),
    .busy          (busy),
    .done          (done),
    .readData      (readData),
    .pc            (pc),
    .instAddr0     (instAddr0),
    .instAddr1     (instAddr1)
  );

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  task automatic checkWord(input string name, input dataWord_u got, input dataWord_u exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got.word, exp.word);
      $display("Result: FAILED");
      $fatal(1, "Data word mismatch");
    end
  endtask

  task automatic checkPc(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Program counter mismatch");
    end
  endtask

  task automatic checkInstAddr(input string name, input logic [`MEM_ADDR_WIDTH-1:0] got,
                               input logic [`MEM_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Instruction address mismatch");
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "Handshake flag mismatch");
    end
  endtask

  // One golden line, entered and left on a falling edge
  task automatic runRequest(input int line);
    int                         base;
    logic [`MEM_ADDR_WIDTH-1:0] expInst;
    base          = line * Columns;
    currentLine   = line;
    control       = goldenMem[base][2:0];
    mode          = goldenMem[base + 1][0];
    resultAddress = goldenMem[base + 2];
    writeData     = goldenMem[base + 3];
    expInst       = goldenMem[base + 6][`MEM_ADDR_WIDTH-1:0];
    start         = 1'b1;
    @(negedge clock);
    start = 1'b0;
    checkFlag("busy", busy, 1'b1); // Request accepted
    while (!done) @(negedge clock);
    checkWord("readData", readData, goldenMem[base + 4]);
    checkInstAddr("instAddr0", instAddr0, expInst);
    checkInstAddr("instAddr1", instAddr1, expInst - 1'b1); // One below the fetch address
    @(negedge clock); // Bank loads on the edge after done
    checkPc("pc", pc, goldenMem[base + 5]);
    checkFlag("busy", busy, 1'b0);
    checkFlag("done", done, 1'b0); // Single cycle pulse
  endtask

  initial begin
    int i;
    reset         = 1'b1;
    start         = 1'b0;
    control       = 3'd0;
    mode          = 1'b0;
    resultAddress = 32'd0;
    writeData     = 32'd0;
    currentLine   = 0;
    goldenLoaded  = 1'b0;
    for (i = 0; i < MaxWords; i++) begin
      goldenMem[i] = 32'hFFFF_FFFF; // End marker
    end
    $readmemh("dv/memoryGolden.txt", goldenMem);
    lineCount = 0;
    while (lineCount < MaxLines && goldenMem[lineCount * Columns] != 32'hFFFF_FFFF) begin
      lineCount++;
    end
    goldenLoaded = 1'b1;

    repeat (10) @(negedge clock);
    reset = 1'b0;
    for (i = 0; i < lineCount; i++) begin
      runRequest(i);
    end

    if (lineCount == 0) begin
      $display("The golden file holds no requests");
      $display("Result: FAILED");
      $fatal(1, "No stimulus");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // Worst request takes about a dozen cycles, twice that per line
  initial begin
    wait (goldenLoaded);
    repeat (20 + 2 * lineCount * 12) @(posedge clock);
    $display("Timeout: request %0d never raised done", currentLine);
    $display("Result: FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/MemoryPkg.sv
src/MemBusIf.sv
src/MemoryAddressHandler.sv
src/StackPointerBank.sv
src/ByteTransferSequencer.sv
src/ByteMemory.sv
src/MemoryAccessUnit.sv
dv/MemoryAccessUnitTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = MemoryAccessUnitTb
FILELIST  = sources.f
PASS      = Result: PASSED

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# Output goes to the terminal and is searched for the pass line
sim: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^$(PASS)$$"

clean:
	rm -rf obj_dir

//--- dv/memoryGolden.txt
// control mode resultAddress writeData expReadData expPc expInstAddr0
// Word, halfword and byte accesses
5 0 80000100 11223344 00000000 00000002 000
5 0 00000100 00000000 11223344 00000004 002
4 0 00000100 00000000 00003344 00000006 004
3 0 000000FF 00000000 00000033 00000008 006
// User pushes, privileged push and pop, user pops
1 0 00000000 000000A1 00000000 0000000A 008
1 0 00000000 000000B2 00000000 0000000C 00A
1 0 00000000 000000C3 00000000 0000000E 00C
1 1 00000000 000000D4 00000000 00000010 00E
2 1 00000000 00000000 000000D4 00000012 010
2 0 00000000 00000000 000000C3 00000014 012
2 0 00000000 00000000 000000B2 00000016 014
2 0 00000000 00000000 000000A1 00000018 016
2 0 00000000 00000000 00000000 0000001A 018
// Jump
6 0 00000123 00000000 00000000 00000125 123
// Fill the user stack from 41 down to 28
1 0 00000000 00000001 00000000 00000127 125
1 0 00000000 00000002 00000000 00000129 127
1 0 00000000 00000003 00000000 0000012B 129
1 0 00000000 00000004 00000000 0000012D 12B
1 0 00000000 00000005 00000000 0000012F 12D
1 0 00000000 00000006 00000000 00000131 12F
1 0 00000000 00000007 00000000 00000133 131
1 0 00000000 00000008 00000000 00000135 133
1 0 00000000 00000009 00000000 00000137 135
1 0 00000000 0000000A 00000000 00000139 137
1 0 00000000 0000000B 00000000 0000013B 139
1 0 00000000 0000000C 00000000 0000013D 13B
1 0 00000000 0000000D 00000000 0000013F 13D
1 0 00000000 0000000E 00000000 00000141 13F
// Push onto a full stack is dropped
1 0 00000000 000000FF 00000000 00000143 141
2 0 00000000 00000000 0000000E 00000145 143
2 0 00000000 00000000 0000000D 00000147 145
